// File: flist.f
logic/if_pkg.sv
logic/if_pc_select.sv
logic/if_fetch_fifo.sv
logic/if_prefetch.sv
logic/if_id_reg.sv
logic/if_stage.sv
test/if_stage_props.sv
test/tb_if_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_if_stage -f flist.f -o tb_if_stage \
  && ./obj_dir/tb_if_stage > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: test/tb_if_stage.sv
////////////////////
// testbench for the instruction fetch stage
// clock, reset, bus memory model and stimulus
// reference target function and compare process
////////////////////

`timescale 1ns/10ps

module tb_if_stage
  import if_pkg::*;
();

  localparam logic [31:0] SEED         = 32'h8ff2c410;
  localparam logic [31:0] PATTERN      = 32'hc0de_1234;
  localparam logic [31:0] DM_HALT      = 32'h0000_0800;
  localparam logic [31:0] DM_EXC       = 32'h0000_0808;
  localparam int          FETCH_DEPTH  = 2;
  // four words answer with a bus error
  localparam logic [31:0] ERR_LO       = 32'h0000_6000;
  localparam logic [31:0] ERR_HI       = 32'h0000_6010;
  localparam int          NEW_TIMEOUT  = 200;
  localparam int          BUSY_TIMEOUT = 50;
  localparam int          IDLE_TIMEOUT = 50;

  logic               clk_i;
  logic               rst_ni;
  logic               req_i;
  addr_t              boot_addr_i;
  logic               instr_req_o;
  addr_t              instr_addr_o;
  logic               instr_gnt_i;
  logic               instr_rvalid_i;
  instr_t             instr_rdata_i;
  logic               instr_err_i;
  logic               pc_set_i;
  pc_sel_e            pc_mux_i;
  exc_pc_sel_e        exc_pc_mux_i;
  logic [IrqVecW-1:0] irq_id_i;
  logic               irq_int_i;
  addr_t              branch_target_i;
  addr_t              csr_mepc_i;
  addr_t              csr_depc_i;
  addr_t              csr_mtvec_i;
  logic               instr_valid_clear_i;
  logic               id_in_ready_i;
  logic               instr_valid_id_o;
  logic               instr_new_id_o;
  instr_t             instr_rdata_id_o;
  logic               instr_fetch_err_o;
  addr_t              pc_id_o;
  addr_t              pc_if_o;
  logic               pc_mismatch_alert_o;
  addr_t              pc_set_target_o;
  logic               csr_mtvec_init_o;
  logic               if_busy_o;

  // per process error counts, new instruction count
  int stim_errs;
  int cmp_errs;
  int timeouts;
  int new_cnt;

  // granted requests waiting for their response, oldest first
  logic [31:0] rsp_addr_q [$];
  int          rsp_due_q  [$];

  if_stage #(
    .DmHaltAddr      (DM_HALT),
    .DmExceptionAddr (DM_EXC),
    .FetchDepth      (FETCH_DEPTH)
  ) UUT (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (req_i),
    .boot_addr_i         (boot_addr_i),
    .instr_req_o         (instr_req_o),
    .instr_addr_o        (instr_addr_o),
    .instr_gnt_i         (instr_gnt_i),
    .instr_rvalid_i      (instr_rvalid_i),
    .instr_rdata_i       (instr_rdata_i),
    .instr_err_i         (instr_err_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .irq_id_i            (irq_id_i),
    .irq_int_i           (irq_int_i),
    .branch_target_i     (branch_target_i),
    .csr_mepc_i          (csr_mepc_i),
    .csr_depc_i          (csr_depc_i),
    .csr_mtvec_i         (csr_mtvec_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_if_o             (pc_if_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o),
    .pc_set_target_o     (pc_set_target_o),
    .csr_mtvec_init_o    (csr_mtvec_init_o),
    .if_busy_o           (if_busy_o)
  );

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic in_err_window(input logic [31:0] a);
    return (a >= ERR_LO) && (a < ERR_HI);
  endfunction

  // expected redirect target, before word alignment
  function automatic logic [31:0] ref_target(
    input pc_sel_e     sel,
    input exc_pc_sel_e exc,
    input logic [4:0]  irq_id,
    input logic        irq_int,
    input logic [31:0] boot,
    input logic [31:0] jump,
    input logic [31:0] mepc,
    input logic [31:0] depc,
    input logic [31:0] mtvec
  );
    logic [4:0]  vec;
    logic [31:0] t;
    // internal interrupts all use vector 31
    vec = irq_int ? 5'd31 : irq_id;
    case (sel)
      PC_BOOT: t = boot;
      PC_JUMP: t = jump;
      PC_ERET: t = mepc;
      PC_DRET: t = depc;
      default: begin
        case (exc)
          EXC_PC_EXC: t = mtvec & 32'hffff_fffc;
          // vectored table entry, one word per index
          EXC_PC_IRQ: t = (mtvec & 32'hffff_ff00) | ({27'd0, vec} << 2);
          EXC_PC_DBD: t = DM_HALT;
          default:    t = DM_EXC;
        endcase
      end
    endcase
    return t;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp_val,
                          input logic [31:0] act_val, inout int errs);
    if (act_val !== exp_val) begin
      $display("Fail %s: expected %h, actual %h at %0t", name, exp_val, act_val, $time);
      errs = errs + 1;
    end
  endtask

  ////////////////////
  // clock
  ////////////////////

  initial begin
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  ////////////////////
  // bus memory model
  ////////////////////

  initial begin : bus_model
    logic [31:0] rng;
    logic [31:0] a;
    int          cyc;
    int          due;
    int          last_due;
    rng            = SEED;
    cyc            = 0;
    last_due       = 0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    forever begin
      @(posedge clk_i);
      cyc = cyc + 1;
      // request accepted on this edge, latency 0 to 3 extra cycles
      if (instr_req_o && instr_gnt_i) begin
        rng = xorshift(rng);
        due = cyc + int'(rng[1:0]);
        // in order, one response per cycle
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_addr_q.push_back(instr_addr_o);
        rsp_due_q.push_back(due);
      end
      @(negedge clk_i);
      rng = xorshift(rng);
      instr_gnt_i = (rng[3:2] != 2'b00);
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
        a = rsp_addr_q.pop_front();
        void'(rsp_due_q.pop_front());
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = a ^ PATTERN;
        instr_err_i    = in_err_window(a);
      end else begin
        instr_rvalid_i = 1'b0;
        instr_rdata_i  = '0;
        instr_err_i    = 1'b0;
      end
    end
  end

  ////////////////////
  // compare process
  ////////////////////

  initial begin : compare
    logic [31:0] model_pc;
    model_pc = '0;
    new_cnt  = 0;
    cmp_errs = 0;
    forever begin
      @(posedge clk_i);
      if (rst_ni) begin
        if (instr_new_id_o) begin
          check_eq("pc_id", model_pc, pc_id_o, cmp_errs);
          check_eq("instr_rdata_id", model_pc ^ PATTERN, instr_rdata_id_o, cmp_errs);
          check_eq("instr_fetch_err", {31'd0, in_err_window(model_pc)},
                   {31'd0, instr_fetch_err_o}, cmp_errs);
          model_pc = model_pc + 32'd4;
          new_cnt  = new_cnt + 1;
        end
        // every sequence here is consistent
        check_eq("pc_mismatch_alert", 32'd0, {31'd0, pc_mismatch_alert_o}, cmp_errs);
        // redirect restarts the model at the aligned target
        if (pc_set_i) begin
          model_pc = ref_target(pc_mux_i, exc_pc_mux_i, irq_id_i, irq_int_i, boot_addr_i,
                                branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i)
                     & 32'hffff_fffc;
        end
      end
    end
  end

  ////////////////////
  // stimulus tasks
  ////////////////////

  task automatic set_pc(input pc_sel_e sel, input exc_pc_sel_e exc,
                        input logic [4:0] id, input logic intr);
    logic [31:0] exp_tgt;
    pc_mux_i     = sel;
    exc_pc_mux_i = exc;
    irq_id_i     = id;
    irq_int_i    = intr;
    pc_set_i     = 1'b1;
    exp_tgt = ref_target(sel, exc, id, intr, boot_addr_i, branch_target_i,
                         csr_mepc_i, csr_depc_i, csr_mtvec_i);
    #1;
    check_eq("pc_set_target", exp_tgt, pc_set_target_o, stim_errs);
    check_eq("csr_mtvec_init", {31'd0, sel == PC_BOOT}, {31'd0, csr_mtvec_init_o}, stim_errs);
    @(negedge clk_i);
    pc_set_i = 1'b0;
  endtask

  task automatic wait_new(input int n, input string what);
    int base;
    int cycles;
    base   = new_cnt;
    cycles = 0;
    while (new_cnt < base + n && cycles < NEW_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (new_cnt < base + n) begin
      $display("Timeout: %s got %0d of %0d new instructions in %0d cycles",
               what, new_cnt - base, n, NEW_TIMEOUT);
      timeouts++;
    end
  endtask

  task automatic wait_busy(input string what);
    int cycles;
    cycles = 0;
    while (!if_busy_o && cycles < BUSY_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!if_busy_o) begin
      $display("Timeout: %s found no outstanding request in %0d cycles", what, BUSY_TIMEOUT);
      timeouts++;
    end
  endtask

  // bus quiet with nothing outstanding means the FIFO has filled up
  task automatic wait_idle(input string what);
    int cycles;
    cycles = 0;
    while ((instr_req_o || if_busy_o) && cycles < IDLE_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (instr_req_o || if_busy_o) begin
      $display("Timeout: %s found the bus still active after %0d cycles", what, IDLE_TIMEOUT);
      timeouts++;
    end
  endtask

  task automatic redirect(input pc_sel_e sel, input exc_pc_sel_e exc, input logic [4:0] id,
                          input logic intr, input int n, input string what);
    set_pc(sel, exc, id, intr);
    wait_new(n, what);
  endtask

  // hold ID back and watch the register freeze
  task automatic stall_id(input int cycles);
    logic [31:0] pc_snap;
    logic [31:0] rdata_snap;
    int          cnt_snap;
    int          k;
    id_in_ready_i = 1'b0;
    // one last pulse may still come from the cycle before
    repeat (2) @(negedge clk_i);
    pc_snap    = pc_id_o;
    rdata_snap = instr_rdata_id_o;
    cnt_snap   = new_cnt;
    for (k = 0; k < cycles; k++) begin
      @(negedge clk_i);
      check_eq("stall pc_id", pc_snap, pc_id_o, stim_errs);
      check_eq("stall instr_rdata_id", rdata_snap, instr_rdata_id_o, stim_errs);
      check_eq("stall instr_valid_id", 32'd1, {31'd0, instr_valid_id_o}, stim_errs);
      check_eq("stall instr_new_id", 32'd0, {31'd0, instr_new_id_o}, stim_errs);
    end
    check_eq("stall new count", 32'(cnt_snap), 32'(new_cnt), stim_errs);
    // FIFO full, bus idle
    check_eq("stall instr_req", 32'd0, {31'd0, instr_req_o}, stim_errs);
    check_eq("stall if_busy", 32'd0, {31'd0, if_busy_o}, stim_errs);
    // head of the FIFO is the next word in sequence
    check_eq("stall pc_if", pc_snap + 32'd4, pc_if_o, stim_errs);
    id_in_ready_i = 1'b1;
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin : stimulus
    int i;
    int total;
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    boot_addr_i         = 32'h0000_1000;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    irq_id_i            = '0;
    irq_int_i           = 1'b0;
    // unaligned on purpose, fetch starts at 2040
    branch_target_i     = 32'h0000_2042;
    csr_mepc_i          = 32'h0000_3100;
    csr_depc_i          = 32'h0000_3200;
    // vectored mode bit set
    csr_mtvec_i         = 32'h0000_4001;
    instr_valid_clear_i = 1'b0;
    id_in_ready_i       = 1'b1;
    stim_errs           = 0;
    timeouts            = 0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    req_i  = 1'b1;
    @(negedge clk_i);

    // boot, then a run of sequential words
    redirect(PC_BOOT, EXC_PC_EXC, 5'd0, 1'b0, 8, "boot");

    // each address source
    redirect(PC_JUMP, EXC_PC_EXC, 5'd0, 1'b0, 4, "jump");
    redirect(PC_ERET, EXC_PC_EXC, 5'd0, 1'b0, 3, "mret");
    redirect(PC_DRET, EXC_PC_EXC, 5'd0, 1'b0, 3, "dret");
    redirect(PC_EXC, EXC_PC_EXC, 5'd0, 1'b0, 3, "exception");
    redirect(PC_EXC, EXC_PC_IRQ, 5'd5, 1'b0, 3, "external irq");
    redirect(PC_EXC, EXC_PC_IRQ, 5'd5, 1'b1, 3, "internal irq");
    redirect(PC_EXC, EXC_PC_DBD, 5'd0, 1'b0, 3, "debug halt");
    redirect(PC_EXC, EXC_PC_DBG_EXC, 5'd0, 1'b0, 3, "debug exception");

    // redirects with requests in flight
    for (i = 0; i < 6; i++) begin
      branch_target_i = 32'h0000_5000 + 32'(i) * 32'h100;
      wait_busy("redirect while busy");
      repeat (i % 2) @(negedge clk_i);
      redirect(PC_JUMP, EXC_PC_EXC, 5'd0, 1'b0, 2 + i, "redirect while busy");
    end

    // back-pressure from ID
    stall_id(16);
    wait_new(6, "resume after stall");

    // faulting fetch, then valid clear
    branch_target_i = ERR_LO;
    id_in_ready_i   = 1'b0;
    set_pc(PC_JUMP, EXC_PC_EXC, 5'd0, 1'b0);
    wait_idle("error window");
    check_eq("error pc_if", ERR_LO, pc_if_o, stim_errs);
    // let exactly one word into ID
    id_in_ready_i = 1'b1;
    @(negedge clk_i);
    id_in_ready_i = 1'b0;
    wait_new(1, "error window");
    check_eq("error pc_id", ERR_LO, pc_id_o, stim_errs);
    check_eq("error instr_fetch_err", 32'd1, {31'd0, instr_fetch_err_o}, stim_errs);
    repeat (2) @(negedge clk_i);
    check_eq("instr_valid_id before clear", 32'd1, {31'd0, instr_valid_id_o}, stim_errs);
    instr_valid_clear_i = 1'b1;
    @(negedge clk_i);
    instr_valid_clear_i = 1'b0;
    check_eq("instr_valid_id after clear", 32'd0, {31'd0, instr_valid_id_o}, stim_errs);
    id_in_ready_i = 1'b1;
    // runs out of the window into good words
    wait_new(6, "after error window");

    repeat (4) @(negedge clk_i);
    total = stim_errs + cmp_errs + timeouts;
    $display("error counts: checks %0d, compares %0d, timeouts %0d",
             stim_errs, cmp_errs, timeouts);
    if (total == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: test/if_stage_props.sv
////////////////////
// bound assertions for the fetch stage
// bus request rules, ID flags, reset values
////////////////////

`timescale 1ns/10ps

module if_stage_props import if_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  instr_req_i,
  input logic  instr_gnt_i,
  input addr_t instr_addr_i,
  input logic  instr_valid_id_i,
  input logic  instr_new_id_i,
  input logic  pc_mismatch_alert_i
);

  // waiting request keeps its address until granted
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_req_i && !instr_gnt_i) |=> (instr_req_i && $stable(instr_addr_i)))
    else $error("request dropped or moved before its grant");

  // word fetches only
  req_align_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_i |-> (instr_addr_i[1:0] == 2'b00))
    else $error("unaligned instruction request");

  new_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_i |-> instr_valid_id_i)
    else $error("new instruction flagged without valid");

  // all quiet right out of reset
  reset_quiet_a: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!instr_req_i && !instr_valid_id_i && !instr_new_id_i &&
                       !pc_mismatch_alert_i))
    else $error("fetch outputs active after reset");

endmodule

bind if_stage if_stage_props u_props (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .instr_req_i         (instr_req_o),
  .instr_gnt_i         (instr_gnt_i),
  .instr_addr_i        (instr_addr_o),
  .instr_valid_id_i    (instr_valid_id_o),
  .instr_new_id_i      (instr_new_id_o),
  .pc_mismatch_alert_i (pc_mismatch_alert_o)
);

// File: logic/if_stage.sv
////////////////////
// instruction fetch stage top level
// address select, prefetch, IF-ID register
////////////////////

`timescale 1ns/10ps

module if_stage import if_pkg::*; #(
  parameter int unsigned DmHaltAddr      = 32'h1A110800,
  parameter int unsigned DmExceptionAddr = 32'h1A110808,
  parameter int unsigned FetchDepth      = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  addr_t              boot_addr_i,
  // instruction bus
  output logic               instr_req_o,
  output addr_t              instr_addr_o,
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  input  instr_t             instr_rdata_i,
  input  logic               instr_err_i,
  // control and CSRs
  input  logic               pc_set_i,
  input  pc_sel_e            pc_mux_i,
  input  exc_pc_sel_e        exc_pc_mux_i,
  input  logic [IrqVecW-1:0] irq_id_i,
  input  logic               irq_int_i,
  input  addr_t              branch_target_i,
  input  addr_t              csr_mepc_i,
  input  addr_t              csr_depc_i,
  input  addr_t              csr_mtvec_i,
  input  logic               instr_valid_clear_i,
  input  logic               id_in_ready_i,
  // to ID stage
  output logic               instr_valid_id_o,
  output logic               instr_new_id_o,
  output instr_t             instr_rdata_id_o,
  output logic               instr_fetch_err_o,
  output addr_t              pc_id_o,
  output addr_t              pc_if_o,
  output logic               pc_mismatch_alert_o,
  output addr_t              pc_set_target_o,
  output logic               csr_mtvec_init_o,
  output logic               if_busy_o
);

  addr_t  fetch_addr_n;
  logic   fetch_valid, fetch_ready, fetch_err;
  instr_t fetch_rdata;
  addr_t  fetch_addr;

  if_pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) u_pc_select (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_id_i         (irq_id_i),
    .irq_int_i        (irq_int_i),
    .pc_set_i         (pc_set_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // target reported unaligned as selected
  assign pc_set_target_o = fetch_addr_n;

  if_prefetch #(
    .FetchDepth (FetchDepth)
  ) u_prefetch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (pc_set_i),
    .branch_addr_i  (fetch_addr_n),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .ready_i        (fetch_ready),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .valid_o        (fetch_valid),
    .rdata_o        (fetch_rdata),
    .addr_o         (fetch_addr),
    .err_o          (fetch_err),
    .busy_o         (if_busy_o)
  );

  if_id_reg u_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_addr_i        (fetch_addr),
    .fetch_err_i         (fetch_err),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_if_o             (pc_if_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

// File: logic/if_id_reg.sv
////////////////////
// IF-ID pipeline register
// valid and new flags, sequential pc alert
////////////////////

`timescale 1ns/10ps

module if_id_reg import if_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   fetch_valid_i,
  input  instr_t fetch_rdata_i,
  input  addr_t  fetch_addr_i,
  input  logic   fetch_err_i,
  input  logic   id_in_ready_i,
  input  logic   pc_set_i,
  input  logic   instr_valid_clear_i,
  output logic   fetch_ready_o,
  output logic   instr_valid_id_o,
  output logic   instr_new_id_o,
  output instr_t instr_rdata_id_o,
  output logic   instr_fetch_err_o,
  output addr_t  pc_id_o,
  output addr_t  pc_if_o,
  output logic   pc_mismatch_alert_o
);

  logic  consume;
  logic  valid_d, valid_q;
  logic  new_q;
  logic  seq_d, seq_q;
  addr_t pc_id_incr;

  // ID stage pulls directly, no extra stall sources here
  assign fetch_ready_o = id_in_ready_i;
  assign consume       = fetch_valid_i & id_in_ready_i;

  // squashed by a pc set, held until ID clears it
  assign valid_d = (consume & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
      seq_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= consume;
      seq_q   <= seq_d;
    end
  end

  // payload, frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (consume) begin
      instr_rdata_id_o  <= fetch_rdata_i;
      instr_fetch_err_o <= fetch_err_i;
      pc_id_o           <= fetch_addr_i;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;
  assign pc_if_o          = fetch_addr_i;

  ////////////////////
  // pc consistency
  ////////////////////

  // no sequence check across a redirect or after a faulting fetch
  assign seq_d = (seq_q | consume) & ~pc_set_i & ~(fetch_valid_i & fetch_err_i);

  assign pc_id_incr = pc_id_o + XLEN'(WordBytes);

  // next word offered must follow the one held in ID
  assign pc_mismatch_alert_o = seq_q & fetch_valid_i & (fetch_addr_i != pc_id_incr);

endmodule

// File: logic/if_prefetch.sv
////////////////////
// prefetcher, bus request engine
// outstanding and stale counts, address tags, fetch FIFO
////////////////////

`timescale 1ns/10ps

module if_prefetch import if_pkg::*; #(
  parameter int unsigned FetchDepth = 2
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   req_i,
  input  logic   branch_i,
  input  addr_t  branch_addr_i,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  instr_t instr_rdata_i,
  input  logic   instr_err_i,
  input  logic   ready_i,
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  output logic   valid_o,
  output instr_t rdata_o,
  output addr_t  addr_o,
  output logic   err_o,
  output logic   busy_o
);

  localparam int unsigned PtrW = $clog2(FetchDepth);
  localparam int unsigned CntW = $clog2(FetchDepth + 1);

  logic            started_q;
  logic            hold_q, hold_stale_q;
  addr_t           hold_addr_q;
  addr_t           next_addr_q, next_addr_d;
  addr_t           branch_addr, new_addr;
  logic [CntW-1:0] out_cnt_q, discard_q, discard_d;
  logic [CntW-1:0] fifo_level, level_eff;
  logic [CntW:0]   inflight;
  logic            present_new, granted, gnt_stale;
  logic            rsp_drop, rsp_valid;
  addr_t           tag_q [FetchDepth];
  logic [PtrW-1:0] tag_wptr_q, tag_rptr_q;

  ////////////////////
  // request side
  ////////////////////

  // word fetches only
  assign branch_addr = {branch_addr_i[XLEN-1:2], 2'b00};
  assign new_addr    = branch_i ? branch_addr : next_addr_q;

  // FIFO is emptied by the flush, so its level no longer counts
  assign level_eff = branch_i ? '0 : fifo_level;
  assign inflight  = {1'b0, out_cnt_q} + {1'b0, level_eff};

  // fresh request only when nothing waits for a grant and there is room
  assign present_new = ~hold_q & req_i & (started_q | branch_i) &
                       (inflight < (CntW+1)'(FetchDepth));

  // a waiting request keeps its address, even across a flush
  assign instr_req_o  = hold_q | present_new;
  assign instr_addr_o = hold_q ? hold_addr_q : new_addr;

  assign granted = instr_req_o & instr_gnt_i;
  // held request from before a flush returns a word nobody wants
  assign gnt_stale = granted & hold_q & (hold_stale_q | branch_i);

  always_comb begin
    if (granted & ~gnt_stale) begin
      next_addr_d = instr_addr_o + XLEN'(WordBytes);
    end else if (branch_i) begin
      next_addr_d = branch_addr;
    end else begin
      next_addr_d = next_addr_q;
    end
  end

  ////////////////////
  // response side
  ////////////////////

  // responses of requests granted before a flush are thrown away
  assign rsp_drop  = instr_rvalid_i & (branch_i | (discard_q != '0));
  assign rsp_valid = instr_rvalid_i & ~rsp_drop;

  always_comb begin
    if (branch_i) begin
      discard_d = out_cnt_q - CntW'(instr_rvalid_i);
    end else begin
      discard_d = discard_q - CntW'(rsp_drop);
    end
    discard_d = discard_d + CntW'(gnt_stale);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q    <= 1'b0;
      hold_q       <= 1'b0;
      hold_stale_q <= 1'b0;
      out_cnt_q    <= '0;
      discard_q    <= '0;
      tag_wptr_q   <= '0;
      tag_rptr_q   <= '0;
    end else begin
      started_q    <= started_q | branch_i;
      hold_q       <= instr_req_o & ~instr_gnt_i;
      hold_stale_q <= instr_req_o & ~instr_gnt_i & hold_q & (hold_stale_q | branch_i);
      out_cnt_q    <= out_cnt_q + CntW'(granted) - CntW'(instr_rvalid_i);
      discard_q    <= discard_d;
      // one tag per grant, popped in order by rvalid
      if (granted) begin
        tag_wptr_q <= tag_wptr_q + 1'b1;
      end
      if (instr_rvalid_i) begin
        tag_rptr_q <= tag_rptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    next_addr_q <= next_addr_d;
    if (instr_req_o) begin
      hold_addr_q <= instr_addr_o;
    end
    if (granted) begin
      tag_q[tag_wptr_q] <= instr_addr_o;
    end
  end

  if_fetch_fifo #(
    .FetchDepth (FetchDepth)
  ) u_fetch_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (branch_i),
    .in_valid_i  (rsp_valid),
    .in_rdata_i  (instr_rdata_i),
    .in_addr_i   (tag_q[tag_rptr_q]),
    .in_err_i    (instr_err_i),
    .out_ready_i (ready_i),
    .out_valid_o (valid_o),
    .out_rdata_o (rdata_o),
    .out_addr_o  (addr_o),
    .out_err_o   (err_o),
    .level_o     (fifo_level)
  );

  assign busy_o = hold_q | (out_cnt_q != '0);

endmodule

// File: logic/if_fetch_fifo.sv
////////////////////
// fall-through FIFO for returned instruction words
// holds word, address and bus error per entry
////////////////////

`timescale 1ns/10ps

module if_fetch_fifo import if_pkg::*; #(
  parameter int unsigned FetchDepth = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             clear_i,
  input  logic                             in_valid_i,
  input  instr_t                           in_rdata_i,
  input  addr_t                            in_addr_i,
  input  logic                             in_err_i,
  input  logic                             out_ready_i,
  output logic                             out_valid_o,
  output instr_t                           out_rdata_o,
  output addr_t                            out_addr_o,
  output logic                             out_err_o,
  output logic [$clog2(FetchDepth+1)-1:0]  level_o
);

  localparam int unsigned PtrW = $clog2(FetchDepth);
  localparam int unsigned CntW = $clog2(FetchDepth + 1);

  // storage, no reset on the payload
  instr_t          rdata_q [FetchDepth];
  addr_t           addr_q  [FetchDepth];
  logic            err_q   [FetchDepth];

  logic [PtrW-1:0] wptr_q, rptr_q;
  logic [CntW-1:0] level_q;
  logic            empty;
  logic            bypass;
  logic            push;
  logic            pop;

  assign empty = (level_q == '0);

  // word goes straight through when nothing is queued ahead of it
  assign bypass = empty & in_valid_i & out_ready_i & ~clear_i;
  assign push   = in_valid_i & ~bypass & ~clear_i;
  assign pop    = ~empty & out_ready_i & ~clear_i;

  // nothing leaves in a flush cycle
  assign out_valid_o = (~empty | in_valid_i) & ~clear_i;
  assign out_rdata_o = empty ? in_rdata_i : rdata_q[rptr_q];
  assign out_addr_o  = empty ? in_addr_i  : addr_q[rptr_q];
  assign out_err_o   = empty ? in_err_i   : err_q[rptr_q];
  assign level_o     = level_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else if (clear_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else begin
      // power of two depth, pointers wrap on their own
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      level_q <= level_q + CntW'(push) - CntW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      rdata_q[wptr_q] <= in_rdata_i;
      addr_q[wptr_q]  <= in_addr_i;
      err_q[wptr_q]   <= in_err_i;
    end
  end

endmodule

// File: logic/if_pc_select.sv
////////////////////
// next fetch address selection
// exception vector, pc mux, mtvec init strobe on boot
////////////////////

`timescale 1ns/10ps

module if_pc_select import if_pkg::*; #(
  parameter int unsigned DmHaltAddr      = 32'h1A110800,
  parameter int unsigned DmExceptionAddr = 32'h1A110808
) (
  input  pc_sel_e             pc_mux_i,
  input  exc_pc_sel_e         exc_pc_mux_i,
  input  logic [IrqVecW-1:0]  irq_id_i,
  input  logic                irq_int_i,
  input  logic                pc_set_i,
  input  addr_t               boot_addr_i,
  input  addr_t               branch_target_i,
  input  addr_t               csr_mepc_i,
  input  addr_t               csr_depc_i,
  input  addr_t               csr_mtvec_i,
  output addr_t               fetch_addr_n_o,
  output logic                csr_mtvec_init_o
);

  logic [IrqVecW-1:0] irq_vec;
  addr_t              exc_pc;

  // internal interrupts are all routed to the nmi slot
  assign irq_vec = irq_int_i ? IrqNmVec : irq_id_i;

  ////////////////////
  // exception target
  ////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      // plain trap, direct mode base
      EXC_PC_EXC:     exc_pc = {csr_mtvec_i[XLEN-1:2], 2'b00};
      // vectored mode, one word slot per cause
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[XLEN-1:8], 1'b0, irq_vec, 2'b00};
      // debug module entry points
      EXC_PC_DBD:     exc_pc = addr_t'(DmHaltAddr);
      EXC_PC_DBG_EXC: exc_pc = addr_t'(DmExceptionAddr);
      default:        exc_pc = {csr_mtvec_i[XLEN-1:2], 2'b00};
    endcase
  end

  ////////////////////
  // fetch address mux
  ////////////////////

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_n_o = boot_addr_i;
      // jump or taken branch from execute
      PC_JUMP: fetch_addr_n_o = branch_target_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      // mret returns to mepc
      PC_ERET: fetch_addr_n_o = csr_mepc_i;
      // dret returns to depc
      PC_DRET: fetch_addr_n_o = csr_depc_i;
      // encodings 5 to 7 are never driven
      default: fetch_addr_n_o = boot_addr_i;
    endcase
  end

  // csr file loads mtvec from the boot address in the boot cycle
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// File: logic/if_pkg.sv
////////////////////
// shared definitions of the instruction fetch stage
// widths, address and word types, mux select enums
////////////////////

package if_pkg;

  // data and address width
  localparam int unsigned XLEN = 32;

  // one aligned word per fetch
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] instr_t;

  // pc advances by one word, no compressed instructions
  localparam int unsigned WordBytes = 4;

  ////////////////////
  // mux selects
  ////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception target inside PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // vectored interrupts, index sits in mtvec bits 6:2
  localparam int unsigned IrqVecW = 5;
  // all internal interrupts share the top vector
  localparam logic [IrqVecW-1:0] IrqNmVec = 5'd31;

endpackage
